//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_cpu
RTL_TOP   ?= cpu
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG)
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only riscv_pkg.sv fetch_stage.sv decode_stage.sv register_file.sv \
		execute_stage.sv mem_wb_stage.sv hazard_unit.sv cpu.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)

//--- cpu.sv
`default_nettype none

module cpu
    import riscv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t im_dout,
    input  word_t mem_dout,
    output word_t im_addr,   // Same as fetch PC
    output word_t mem_addr,
    output word_t mem_din,
    output logic  mem_we
);

    // ID
    word_t     inst_id, pc_id, pc4_id, rd0, rd1;
    reg_addr_t ra0, ra1;
    logic      re0_id, re1_id;

    // EX
    word_t     pc_ex, pc4_ex, imm_ex, rd0_ex, rd1_ex;
    reg_addr_t ra0_ex, ra1_ex, wa_ex;
    logic      re0_ex, re1_ex, we_ex, dm_we_ex, src1_pc_ex, src2_imm_ex, jal_ex, jalr_ex;
    alu_func_t alu_func_ex;
    br_type_t  br_type_ex;
    wd_sel_t   wd_sel_ex;
    pc_sel_t   pc_sel;
    word_t     jalr_target, br_target;

    // MEM and WB
    word_t     pc4_mem, imm_mem, wb_data;
    reg_addr_t wa_mem, wa_wb;
    logic      we_mem, we_wb;
    wd_sel_t   wd_sel_mem;

    // Hazard control
    logic      stall_if, stall_id, bubble_ex, flush_id, flush_ex;
    fwd_sel_t  fwd_a, fwd_b;
    word_t     fwd_mem_data;

    fetch_stage u_fetch (.pc_if(im_addr), .*);

    decode_stage u_decode (.*);

    register_file u_rf (.wa(wa_wb), .wd(wb_data), .we(we_wb), .*);

    execute_stage u_execute (.*);

    mem_wb_stage u_mem_wb (.*);

    hazard_unit u_hazard (.*);

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      bubble_ex,
    input  logic      flush_ex,
    input  word_t     inst_id,
    input  word_t     pc_id,
    input  word_t     pc4_id,
    input  word_t     rd0,
    input  word_t     rd1,
    output reg_addr_t ra0,
    output reg_addr_t ra1,
    output logic      re0_id,
    output logic      re1_id,
    output word_t     pc_ex,
    output word_t     pc4_ex,
    output word_t     imm_ex,
    output word_t     rd0_ex,
    output word_t     rd1_ex,
    output reg_addr_t ra0_ex,
    output reg_addr_t ra1_ex,
    output reg_addr_t wa_ex,
    output logic      re0_ex,
    output logic      re1_ex,
    output logic      we_ex,
    output logic      dm_we_ex,
    output logic      src1_pc_ex,
    output logic      src2_imm_ex,
    output logic      jal_ex,
    output logic      jalr_ex,
    output alu_func_t alu_func_ex,
    output br_type_t  br_type_ex,
    output wd_sel_t   wd_sel_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      imm;
    logic       we, dm_we, src1_pc, src2_imm, jal, jalr;
    alu_func_t  alu_op, alu_func;
    br_type_t   br_type;
    wd_sel_t    wd_sel;

    assign opcode   = inst_id[6:0];
    assign funct3   = inst_id[14:12];
    assign funct7_5 = inst_id[30];
    assign ra0      = inst_id[19:15];
    assign ra1      = inst_id[24:20];

    assign imm_i = {{20{inst_id[31]}}, inst_id[31:20]};
    assign imm_s = {{20{inst_id[31]}}, inst_id[31:25], inst_id[11:7]};
    assign imm_b = {{19{inst_id[31]}}, inst_id[31], inst_id[7], inst_id[30:25],
                    inst_id[11:8], 1'b0};
    assign imm_u = {inst_id[31:12], 12'b0};
    assign imm_j = {{11{inst_id[31]}}, inst_id[31], inst_id[19:12], inst_id[20],
                    inst_id[30:21], 1'b0};

    // Shared by register and immediate ALU forms
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OP_R && funct7_5) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        re0_id   = 1'b0;
        re1_id   = 1'b0;
        we       = 1'b0;
        dm_we    = 1'b0;
        src1_pc  = 1'b0;
        src2_imm = 1'b1;
        jal      = 1'b0;
        jalr     = 1'b0;
        alu_func = ALU_ADD;
        br_type  = BR_NONE;
        wd_sel   = WD_ALU;
        imm      = imm_i;
        case (opcode)
            OP_R: begin
                {re0_id, re1_id, we} = 3'b111;
                src2_imm = 1'b0;
                alu_func = alu_op;
            end
            OP_I: begin
                {re0_id, we} = 2'b11;
                alu_func = alu_op;
            end
            OP_LOAD: begin
                {re0_id, we} = 2'b11;
                wd_sel = WD_MEM;
            end
            OP_STORE: begin
                {re0_id, re1_id, dm_we} = 3'b111;
                imm = imm_s;
            end
            OP_BRANCH: begin
                {re0_id, re1_id, src1_pc} = 3'b111;
                imm = imm_b;
                case (funct3)
                    3'b000:  br_type = BR_EQ;
                    3'b100:  br_type = BR_LT;
                    3'b110:  br_type = BR_LTU;
                    default: br_type = BR_NONE;  // bne/bge/bgeu not supported
                endcase
            end
            OP_JAL: begin
                {we, src1_pc, jal} = 3'b111;
                imm    = imm_j;
                wd_sel = WD_PC4;
            end
            OP_JALR: begin
                {re0_id, we, jalr} = 3'b111;
                wd_sel = WD_PC4;
            end
            OP_LUI: begin
                we       = 1'b1;
                imm      = imm_u;
                alu_func = ALU_PASS2;
                wd_sel   = WD_IMM;
            end
            OP_AUIPC: begin
                {we, src1_pc} = 2'b11;
                imm = imm_u;
            end
            default: src2_imm = 1'b0;
        endcase
    end

    // ID/EX control, bubble clears every enable
    always_ff @(posedge clk) begin
        if (rst || bubble_ex || flush_ex) begin
            re0_ex     <= 1'b0;
            re1_ex     <= 1'b0;
            we_ex      <= 1'b0;
            dm_we_ex   <= 1'b0;
            jal_ex     <= 1'b0;
            jalr_ex    <= 1'b0;
            br_type_ex <= BR_NONE;
        end else begin
            re0_ex     <= re0_id;
            re1_ex     <= re1_id;
            we_ex      <= we;
            dm_we_ex   <= dm_we;
            jal_ex     <= jal;
            jalr_ex    <= jalr;
            br_type_ex <= br_type;
        end
    end

    always_ff @(posedge clk) begin
        pc_ex       <= pc_id;
        pc4_ex      <= pc4_id;
        imm_ex      <= imm;
        rd0_ex      <= rd0;
        rd1_ex      <= rd1;
        ra0_ex      <= ra0;
        ra1_ex      <= ra1;
        wa_ex       <= inst_id[11:7];
        src1_pc_ex  <= src1_pc;
        src2_imm_ex <= src2_imm;
        alu_func_ex <= alu_func;
        wd_sel_ex   <= wd_sel;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     pc_ex,
    input  word_t     pc4_ex,
    input  word_t     imm_ex,
    input  word_t     rd0_ex,
    input  word_t     rd1_ex,
    input  reg_addr_t wa_ex,
    input  logic      we_ex,
    input  logic      dm_we_ex,
    input  logic      src1_pc_ex,
    input  logic      src2_imm_ex,
    input  logic      jal_ex,
    input  logic      jalr_ex,
    input  alu_func_t alu_func_ex,
    input  br_type_t  br_type_ex,
    input  wd_sel_t   wd_sel_ex,
    input  fwd_sel_t  fwd_a,
    input  fwd_sel_t  fwd_b,
    input  word_t     fwd_mem_data,
    input  word_t     wb_data,
    output pc_sel_t   pc_sel,
    output word_t     jalr_target,
    output word_t     br_target,
    output word_t     mem_addr,
    output word_t     mem_din,
    output word_t     pc4_mem,
    output word_t     imm_mem,
    output reg_addr_t wa_mem,
    output logic      we_mem,
    output logic      mem_we,
    output wd_sel_t   wd_sel_mem
);

    word_t op_a, op_b;
    word_t src1, src2;
    word_t alu_res;
    logic  br_taken;

    function automatic word_t fwd_pick(fwd_sel_t sel, word_t raw, word_t from_mem,
                                       word_t from_wb);
        case (sel)
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return raw;
        endcase
    endfunction

    assign op_a = fwd_pick(fwd_a, rd0_ex, fwd_mem_data, wb_data);
    assign op_b = fwd_pick(fwd_b, rd1_ex, fwd_mem_data, wb_data);
    assign src1 = src1_pc_ex ? pc_ex : op_a;
    assign src2 = src2_imm_ex ? imm_ex : op_b;

    always_comb begin
        case (alu_func_ex)
            ALU_SUB:   alu_res = src1 - src2;
            ALU_AND:   alu_res = src1 & src2;
            ALU_OR:    alu_res = src1 | src2;
            ALU_XOR:   alu_res = src1 ^ src2;
            ALU_SLT:   alu_res = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU:  alu_res = {31'b0, src1 < src2};
            ALU_SLL:   alu_res = src1 << src2[4:0];
            ALU_SRL:   alu_res = src1 >> src2[4:0];
            ALU_SRA:   alu_res = $signed(src1) >>> src2[4:0];
            ALU_PASS2: alu_res = src2;
            default:   alu_res = src1 + src2;
        endcase
    end

    // Compare uses the forwarded register values, not the ALU sources
    always_comb begin
        case (br_type_ex)
            BR_EQ:   br_taken = (op_a == op_b);
            BR_LT:   br_taken = ($signed(op_a) < $signed(op_b));
            BR_LTU:  br_taken = (op_a < op_b);
            default: br_taken = 1'b0;
        endcase
    end

    assign pc_sel      = jalr_ex ? PC_JALR : (jal_ex || br_taken) ? PC_TARGET : PC_SEQ;
    assign jalr_target = alu_res & ~32'h1;
    assign br_target   = alu_res;   // pc + imm

    always_ff @(posedge clk) begin
        if (rst) begin
            we_mem <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            we_mem <= we_ex;
            mem_we <= dm_we_ex;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr   <= alu_res;
        mem_din    <= op_b;
        pc4_mem    <= pc4_ex;
        imm_mem    <= imm_ex;
        wa_mem     <= wa_ex;
        wd_sel_mem <= wd_sel_ex;
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

module fetch_stage
    import riscv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall_if,
    input  logic    stall_id,
    input  logic    flush_id,
    input  pc_sel_t pc_sel,
    input  word_t   jalr_target,
    input  word_t   br_target,
    input  word_t   im_dout,
    output word_t   pc_if,
    output word_t   inst_id,
    output word_t   pc_id,
    output word_t   pc4_id
);

    word_t pc4_if;
    word_t pc_next;

    assign pc4_if = pc_if + 32'd4;

    always_comb begin
        case (pc_sel)
            PC_JALR:   pc_next = jalr_target;
            PC_TARGET: pc_next = br_target;
            default:   pc_next = pc4_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc_if <= RESET_PC;
        else if (!stall_if)
            pc_if <= pc_next;
    end

    // IF/ID, flushed slot becomes a no-op
    always_ff @(posedge clk) begin
        if (rst || flush_id)
            inst_id <= NOP_INST;
        else if (!stall_id)
            inst_id <= im_dout;
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            pc_id  <= pc_if;
            pc4_id <= pc4_if;
        end
    end

endmodule

`default_nettype wire

//--- hazard_unit.sv
`default_nettype none

module hazard_unit
    import riscv_pkg::*;
(
    input  reg_addr_t ra0_ex,
    input  reg_addr_t ra1_ex,
    input  reg_addr_t wa_mem,
    input  reg_addr_t wa_wb,
    input  reg_addr_t ra0,
    input  reg_addr_t ra1,
    input  reg_addr_t wa_ex,
    input  logic      re0_ex,
    input  logic      re1_ex,
    input  logic      we_mem,
    input  logic      we_wb,
    input  logic      we_ex,
    input  logic      re0_id,
    input  logic      re1_id,
    input  wd_sel_t   wd_sel_ex,
    input  wd_sel_t   wd_sel_mem,
    input  word_t     mem_addr,
    input  word_t     pc4_mem,
    input  word_t     imm_mem,
    input  pc_sel_t   pc_sel,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output word_t     fwd_mem_data,
    output logic      stall_if,
    output logic      stall_id,
    output logic      bubble_ex,
    output logic      flush_id,
    output logic      flush_ex
);

    logic load_use;

    // MEM is younger than WB, so it wins
    function automatic fwd_sel_t fwd_pick(reg_addr_t ra, logic re);
        if (!re || ra == 5'd0)
            return FWD_NONE;
        else if (we_mem && wa_mem == ra)
            return FWD_MEM;
        else if (we_wb && wa_wb == ra)
            return FWD_WB;
        else
            return FWD_NONE;
    endfunction

    assign fwd_a = fwd_pick(ra0_ex, re0_ex);
    assign fwd_b = fwd_pick(ra1_ex, re1_ex);

    // Load data is not ready in MEM; that case is covered by the stall
    always_comb begin
        case (wd_sel_mem)
            WD_PC4:  fwd_mem_data = pc4_mem;
            WD_IMM:  fwd_mem_data = imm_mem;
            default: fwd_mem_data = mem_addr;
        endcase
    end

    assign load_use = we_ex && wd_sel_ex == WD_MEM && wa_ex != 5'd0 &&
                      ((re0_id && ra0 == wa_ex) || (re1_id && ra1 == wa_ex));

    assign stall_if  = load_use;
    assign stall_id  = load_use;
    assign bubble_ex = load_use;

    assign flush_id = (pc_sel != PC_SEQ);  // Taken branch or jump
    assign flush_ex = (pc_sel != PC_SEQ);

endmodule

`default_nettype wire

//--- mem_wb_stage.sv
`default_nettype none

module mem_wb_stage
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     mem_addr,
    input  word_t     pc4_mem,
    input  word_t     imm_mem,
    input  word_t     mem_dout,
    input  reg_addr_t wa_mem,
    input  logic      we_mem,
    input  wd_sel_t   wd_sel_mem,
    output reg_addr_t wa_wb,
    output logic      we_wb,
    output word_t     wb_data
);

    word_t   alu_wb, pc4_wb, imm_wb, load_wb;
    wd_sel_t wd_sel_wb;

    always_ff @(posedge clk) begin
        if (rst)
            we_wb <= 1'b0;
        else
            we_wb <= we_mem;
    end

    always_ff @(posedge clk) begin
        alu_wb    <= mem_addr;   // ALU result doubles as the memory address
        pc4_wb    <= pc4_mem;
        imm_wb    <= imm_mem;
        load_wb   <= mem_dout;
        wa_wb     <= wa_mem;
        wd_sel_wb <= wd_sel_mem;
    end

    always_comb begin
        case (wd_sel_wb)
            WD_PC4:  wb_data = pc4_wb;
            WD_MEM:  wb_data = load_wb;
            WD_IMM:  wb_data = imm_wb;
            default: wb_data = alu_wb;
        endcase
    end

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none

module register_file
    import riscv_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t ra0,
    input  reg_addr_t ra1,
    input  reg_addr_t wa,
    input  word_t     wd,
    input  logic      we,
    output word_t     rd0,
    output word_t     rd1
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // Write-through so decode sees the WB result in the same cycle
    assign rd0 = (ra0 == 5'd0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

`default_nettype wire

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_func_t;
    typedef logic [1:0]  br_type_t;
    typedef logic [1:0]  wd_sel_t;
    typedef logic [1:0]  pc_sel_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam alu_func_t ALU_ADD   = 4'd0;
    localparam alu_func_t ALU_SUB   = 4'd1;
    localparam alu_func_t ALU_AND   = 4'd2;
    localparam alu_func_t ALU_OR    = 4'd3;
    localparam alu_func_t ALU_XOR   = 4'd4;
    localparam alu_func_t ALU_SLT   = 4'd5;
    localparam alu_func_t ALU_SLTU  = 4'd6;
    localparam alu_func_t ALU_SLL   = 4'd7;
    localparam alu_func_t ALU_SRL   = 4'd8;
    localparam alu_func_t ALU_SRA   = 4'd9;
    localparam alu_func_t ALU_PASS2 = 4'd10;  // Second operand straight through

    localparam br_type_t BR_NONE = 2'd0;
    localparam br_type_t BR_EQ   = 2'd1;
    localparam br_type_t BR_LT   = 2'd2;
    localparam br_type_t BR_LTU  = 2'd3;

    localparam wd_sel_t WD_ALU = 2'd0;
    localparam wd_sel_t WD_PC4 = 2'd1;
    localparam wd_sel_t WD_MEM = 2'd2;
    localparam wd_sel_t WD_IMM = 2'd3;

    localparam pc_sel_t PC_SEQ    = 2'd0;
    localparam pc_sel_t PC_JALR   = 2'd1;
    localparam pc_sel_t PC_TARGET = 2'd2;  // Branch or jal

    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    localparam word_t NOP_INST = 32'h0000_0033;  // add x0,x0,x0
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

module tb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_din,
    input  logic [31:0] im_addr,
    input  logic [31:0] exp_addr,
    input  logic [31:0] exp_val,
    input  int          test_id,
    output logic        done,
    output int          pass_count,
    output int          fail_count
);

    localparam logic [31:0] FIRST_PC   = 32'h0000_0000;
    localparam logic [31:0] RESULT_LOW = 32'h0000_0080;  // Stores below are data traffic

    logic rst_q;

    initial begin
        rst_q      = 1'b0;
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
    end

    // Sampled on the rising edge before the DUT registers update
    always @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            done <= 1'b0;
            if (rst_q && mem_we !== 1'b0) begin
                $display("Test %0d: store strobe not low while reset is held", test_id);
                fail_count <= fail_count + 1;
            end
        end else begin
            if (rst_q && im_addr !== FIRST_PC) begin
                $display("FAIL at %0t: test %0d first fetch address %h, expected %h",
                         $time, test_id, im_addr, FIRST_PC);
                fail_count <= fail_count + 1;
            end
            if (!done && mem_we === 1'b1 && mem_addr >= RESULT_LOW) begin
                done <= 1'b1;
                if (mem_addr === exp_addr && mem_din === exp_val) begin
                    $display("PASS test %0d: [%h] = %h", test_id, mem_addr, mem_din);
                    pass_count <= pass_count + 1;
                end else begin
                    $display("FAIL at %0t: test %0d expected [%h] = %h, got [%h] = %h",
                             $time, test_id, exp_addr, exp_val, mem_addr, mem_din);
                    fail_count <= fail_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_cpu.sv
`default_nettype none

module tb_cpu;

    localparam int          NTEST    = 7;
    localparam int          PROG_LEN = 16;
    localparam int          LIMIT    = NTEST * (200 + 16);
    localparam logic [31:0] RES_ADDR = 32'h0000_0080;
    localparam logic [31:0] NOP      = 32'h0000_0033;

    logic        clk, rst, mem_we, done;
    logic [31:0] im_addr, im_dout, mem_addr, mem_din, mem_dout;
    logic [31:0] exp_addr, exp_val;
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] prog [NTEST][PROG_LEN];
    logic [31:0] exp_val_tab [NTEST];
    int          pass_count, fail_count, test_id, cycles, n;

    cpu uut (
        .clk(clk), .rst(rst), .im_dout(im_dout), .mem_dout(mem_dout),
        .im_addr(im_addr), .mem_addr(mem_addr), .mem_din(mem_din), .mem_we(mem_we)
    );

    tb_checker chk (
        .clk(clk), .rst(rst), .mem_we(mem_we), .mem_addr(mem_addr), .mem_din(mem_din),
        .im_addr(im_addr), .exp_addr(exp_addr), .exp_val(exp_val), .test_id(test_id),
        .done(done), .pass_count(pass_count), .fail_count(fail_count)
    );

    assign im_dout  = imem[im_addr[7:2]];
    assign mem_dout = dmem[mem_addr[7:2]];

    // Data memory refilled with an address pattern during reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= 32'hC0DE_0000 | (i * 4);
        end else if (mem_we) begin
            dmem[mem_addr[7:2]] <= mem_din;
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial cycles = 0;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: test %0d gave no result store within %0d cycles", test_id, LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_sw(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(int t, logic [31:0] w);
        prog[t][n] = w;
        n++;
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(int t, logic [4:0] rd, logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit(t, {hi[19:0], rd, 7'b0110111});
        emit(t, enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic finish_prog(int t, logic [4:0] rs);
        emit(t, enc_sw(RES_ADDR[11:0], rs, 5'd0));
        emit(t, enc_j(21'd0, 5'd0));  // Spin here
    endtask

    task automatic build_table();
        logic [31:0] a, b, e3, e4, e5, e6, e7, e8;
        for (int t = 0; t < NTEST; t++) begin
            for (int i = 0; i < PROG_LEN; i++)
                prog[t][i] = NOP;
            a = $urandom();
            b = $urandom();
            n = 0;
            case (t)
                0, 1: begin  // Back-to-back dependent ALU chain
                    load_const(t, 5'd1, a);
                    load_const(t, 5'd2, b);
                    emit(t, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
                    emit(t, enc_r(7'h00, 5'd1, 5'd3, 3'b100, 5'd4));
                    emit(t, enc_i(12'd3, 5'd4, 3'b001, 5'd5, 7'b0010011));
                    emit(t, enc_i({7'b0100000, 5'd2}, 5'd5, 3'b101, 5'd6, 7'b0010011));
                    emit(t, enc_r(7'h20, 5'd5, 5'd6, 3'b000, 5'd7));
                    emit(t, enc_r(7'h00, 5'd1, 5'd7, 3'b011, 5'd8));
                    emit(t, enc_r(7'h00, 5'd7, 5'd8, 3'b000, 5'd9));
                    finish_prog(t, 5'd9);
                    e3 = a + b;
                    e4 = e3 ^ a;
                    e5 = e4 << 3;
                    e6 = $signed(e5) >>> 2;
                    e7 = e6 - e5;
                    e8 = (e7 < a) ? 32'd1 : 32'd0;
                    exp_val_tab[t] = e8 + e7;
                end
                2: begin  // Store, load, then use at once
                    load_const(t, 5'd1, a);
                    load_const(t, 5'd2, b);
                    emit(t, enc_sw(12'h040, 5'd1, 5'd0));
                    emit(t, enc_i(12'h040, 5'd0, 3'b010, 5'd3, 7'b0000011));
                    emit(t, enc_r(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
                    finish_prog(t, 5'd4);
                    exp_val_tab[t] = a + b;
                end
                3, 4: begin  // Each taken branch skips its addi
                    if (t == 4)
                        b = a;
                    load_const(t, 5'd1, a);
                    load_const(t, 5'd2, b);
                    emit(t, enc_i(12'd0, 5'd0, 3'b000, 5'd5, 7'b0010011));
                    emit(t, enc_b(13'd8, 5'd2, 5'd1, 3'b000));
                    emit(t, enc_i(12'd1, 5'd5, 3'b000, 5'd5, 7'b0010011));
                    emit(t, enc_b(13'd8, 5'd2, 5'd1, 3'b100));
                    emit(t, enc_i(12'd2, 5'd5, 3'b000, 5'd5, 7'b0010011));
                    emit(t, enc_b(13'd8, 5'd2, 5'd1, 3'b110));
                    emit(t, enc_i(12'd4, 5'd5, 3'b000, 5'd5, 7'b0010011));
                    emit(t, enc_b(13'd8, 5'd1, 5'd1, 3'b000));
                    emit(t, enc_i(12'd8, 5'd5, 3'b000, 5'd5, 7'b0010011));
                    finish_prog(t, 5'd5);
                    exp_val_tab[t] = ((a == b) ? 32'd0 : 32'd1) +
                                     (($signed(a) < $signed(b)) ? 32'd0 : 32'd2) +
                                     ((a < b) ? 32'd0 : 32'd4);
                end
                5: begin  // jal at 0, jalr at 12 with base 21
                    emit(t, enc_j(21'd8, 5'd1));
                    emit(t, enc_i(12'h055, 5'd0, 3'b000, 5'd1, 7'b0010011));
                    emit(t, enc_i(12'd21, 5'd0, 3'b000, 5'd2, 7'b0010011));
                    emit(t, enc_i(12'd0, 5'd2, 3'b000, 5'd3, 7'b1100111));
                    emit(t, enc_i(12'h055, 5'd0, 3'b000, 5'd1, 7'b0010011));
                    emit(t, {20'd0, 5'd6, 7'b0010111});  // auipc x6 at the jalr target
                    emit(t, enc_i(12'd8, 5'd3, 3'b001, 5'd4, 7'b0010011));
                    emit(t, enc_r(7'h00, 5'd1, 5'd4, 3'b000, 5'd5));
                    emit(t, enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7));
                    finish_prog(t, 5'd7);
                    exp_val_tab[t] = ((32'd12 + 32'd4) << 8) + (32'd0 + 32'd4) +
                                     (32'd21 & ~32'd1);
                end
                default: begin  // lui at 0, auipc at 4
                    emit(t, {a[19:0], 5'd1, 7'b0110111});
                    emit(t, {b[19:0], 5'd2, 7'b0010111});
                    emit(t, enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
                    finish_prog(t, 5'd3);
                    exp_val_tab[t] = {a[19:0], 12'b0} ^ (32'd4 + {b[19:0], 12'b0});
                end
            endcase
        end
    endtask

    initial begin
        rst      = 1'b1;
        exp_addr = RES_ADDR;
        exp_val  = '0;
        test_id  = 0;
        for (int i = 0; i < 64; i++)
            imem[i] = NOP;
        void'($urandom(7628));
        build_table();
        for (int t = 0; t < NTEST; t++) begin
            @(negedge clk);
            rst     = 1'b1;
            test_id = t;
            exp_val = exp_val_tab[t];
            for (int i = 0; i < 64; i++)
                imem[i] = (i < PROG_LEN) ? prog[t][i] : NOP;
            repeat (16) @(negedge clk);
            rst = 1'b0;
            while (!done)
                @(negedge clk);
        end
        @(negedge clk);
        $display("Done: %0d tests, %0d passed, %0d failed", NTEST, pass_count, fail_count);
        if (fail_count == 0 && pass_count == NTEST)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
riscv_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
mem_wb_stage.sv
hazard_unit.sv
cpu.sv
tb_checker.sv
tb_cpu.sv
